// ==== hw/lc3b_isa_pkg.sv ====
package lc3b_isa_pkg;

	// opcode field, ir[15:12]
	typedef enum logic [3:0] {
		op_br   = 4'h0,
		op_add  = 4'h1,
		op_ldb  = 4'h2,
		op_stb  = 4'h3,
		op_jsr  = 4'h4,
		op_and  = 4'h5,
		op_ldr  = 4'h6,
		op_str  = 4'h7,
		op_rti  = 4'h8,
		op_not  = 4'h9,
		op_ldi  = 4'ha,
		op_sti  = 4'hb,
		op_jmp  = 4'hc,
		op_shf  = 4'hd,
		op_lea  = 4'he,
		op_trap = 4'hf
	} opcode_e;

	typedef logic [2:0]  reg_idx_t;	// r0..r7
	typedef logic [15:0] instr_t;
	typedef logic [15:0] addr_t;	// byte address, instructions on even bytes

	function automatic opcode_e opcode_of(instr_t ir);
		return opcode_e'(ir[15:12]);
	endfunction

	// dr for alu/loads, store source for stores
	function automatic reg_idx_t dr_of(instr_t ir);
		return ir[11:9];
	endfunction

	function automatic reg_idx_t sr1_of(instr_t ir);
		return ir[8:6];	// also baseR
	endfunction

	function automatic reg_idx_t sr2_of(instr_t ir);
		return ir[2:0];
	endfunction

endpackage

// ==== hw/lc3b_pipe_pkg.sv ====
package lc3b_pipe_pkg;

	import lc3b_isa_pkg::*;

	// one pipeline slot, 33 bits
	// bubble is valid low with a zero ir, which decodes as a br that never branches
	typedef struct packed {
		logic   valid;
		addr_t  pc;
		instr_t ir;
	} stage_t;

	// which register fields an instruction touches
	typedef struct packed {
		logic writes_dr;	// writes ir[11:9]
		logic reads_sr1;	// reads ir[8:6]
		logic reads_sr2;	// reads ir[2:0]
		logic reads_store_src;	// store data register
	} operand_use_t;

	localparam stage_t stage_empty = '0;	// the bubble

endpackage

// ==== hw/fetch_unit.sv ====
`timescale 1ns/100ps

// pc and fetch address for the front end
// instruction memory sits outside and answers in the same cycle
module fetch_unit
	import lc3b_isa_pkg::*, lc3b_pipe_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   stall,	// hold pc, load-use or shadow
	input  logic   squash,	// hold pc while IF/ID is cleared
	input  logic   redirect,	// resolved target, one cycle pulse
	input  addr_t  redirect_pc,
	input  instr_t fetch_ir,	// word at fetch_addr
	output addr_t  fetch_addr,
	output stage_t fetched	// candidate for IF/ID
);

	addr_t pc;
	addr_t pc_next;

	// redirect wins over hold, hold wins over advance
	always_comb
	begin
		if (redirect)
			pc_next = redirect_pc;
		else if (stall || squash)
			pc_next = pc;	// same word is fetched again
		else
			pc_next = pc + 16'd2;	// next word
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			pc <= '0;	// boot vector
		else
			pc <= pc_next;
	end

	assign fetch_addr = pc;

	// every fetched word is a real candidate; IF/ID decides whether it lands
	always_comb
	begin
		fetched.valid = 1'b1;
		fetched.pc    = pc;
		fetched.ir    = fetch_ir;
	end

endmodule

// ==== hw/stage_regs.sv ====
`timescale 1ns/100ps

// IF/ID and ID/EX slots
// stall keeps IF/ID and drops a bubble into ID/EX
// squash throws away the IF/ID occupant
module stage_regs
	import lc3b_pipe_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   stall,
	input  logic   squash,
	input  stage_t fetched,	// from fetch unit
	output stage_t if_id,
	output stage_t id_ex	// goes to execute
);

	stage_t if_id_next;
	stage_t id_ex_next;
	stage_t if_id_fwd;	// what decode hands on this cycle

	// a squashed instruction travels on as a bubble
	assign if_id_fwd = squash ? stage_empty : if_id;

	always_comb
	begin
		if (stall)
			if_id_next = if_id;	// hold decode
		else if (squash)
			if_id_next = stage_empty;	// kill the shadow occupant
		else
			if_id_next = fetched;
	end

	always_comb
	begin
		if (stall)
			id_ex_next = stage_empty;	// bubble into execute
		else
			id_ex_next = if_id_fwd;
	end

	// both slots come out of reset empty
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			if_id <= stage_empty;
			id_ex <= stage_empty;
		end
		else
		begin
			if_id <= if_id_next;
			id_ex <= id_ex_next;
		end
	end

endmodule

// ==== hw/operand_use_decoder.sv ====
`timescale 1ns/100ps

// register field usage per opcode
// only fields named in the word are tracked; the r7 link of jsr/trap is not
module operand_use_decoder
	import lc3b_isa_pkg::*, lc3b_pipe_pkg::*;
(
	input  instr_t       ir,
	output operand_use_t uses
);

	opcode_e op;

	assign op = opcode_of(ir);

	always_comb
	begin
		uses = '0;
		case (op)
			op_add, op_and:
			begin
				uses.writes_dr = 1'b1;
				uses.reads_sr1 = 1'b1;
				uses.reads_sr2 = !ir[5];	// ir[5] set means imm5
			end
			op_not, op_shf:
			begin
				uses.writes_dr = 1'b1;
				uses.reads_sr1 = 1'b1;
			end
			op_ldb, op_ldr, op_ldi:
			begin
				uses.writes_dr = 1'b1;
				uses.reads_sr1 = 1'b1;	// base register
			end
			op_lea:
				uses.writes_dr = 1'b1;	// pc relative, no source
			op_stb, op_str, op_sti:
			begin
				uses.reads_sr1       = 1'b1;	// base
				uses.reads_store_src = 1'b1;	// data in ir[11:9]
			end
			op_jmp:
				uses.reads_sr1 = 1'b1;	// baseR, ret is jmp r7
			op_jsr:
				uses.reads_sr1 = !ir[11];	// jsrr form
			default:
				uses = '0;	// br, rti, trap
		endcase
	end

endmodule

// ==== hw/hazard_unit.sv ====
`timescale 1ns/100ps

// load-use and control shadow detection for the front end
module hazard_unit
	import lc3b_isa_pkg::*, lc3b_pipe_pkg::*;
#(
	parameter logic [2:0] resolve_delay = 3'd5	// shadow length, 2 to 7
)
(
	input  logic   clk,
	input  logic   rst_n,
	input  stage_t if_id,
	input  stage_t id_ex,
	output logic   stall,
	output logic   squash
);

	operand_use_t if_id_use;
	operand_use_t id_ex_use;
	opcode_e      if_id_op;
	opcode_e      id_ex_op;
	reg_idx_t     ld_dr;	// load destination in ID/EX
	logic         ex_is_load;
	logic         load_use;
	logic         moves_pc;
	logic         shadow_start;
	logic [2:0]   shadow_cnt;

	operand_use_decoder if_id_dec
	(
		.ir   (if_id.ir),
		.uses (if_id_use)
	);

	operand_use_decoder id_ex_dec
	(
		.ir   (id_ex.ir),
		.uses (id_ex_use)
	);

	assign if_id_op = opcode_of(if_id.ir);
	assign id_ex_op = opcode_of(id_ex.ir);
	assign ld_dr    = dr_of(id_ex.ir);

	assign ex_is_load = id_ex.valid && id_ex_use.writes_dr &&
		(id_ex_op inside {op_ldb, op_ldr, op_ldi});

	// load result is not ready for the next instruction, one bubble covers it
	always_comb
	begin
		load_use = 1'b0;
		if (ex_is_load && if_id.valid)
		begin
			if (if_id_use.reads_sr1 && (sr1_of(if_id.ir) == ld_dr))
				load_use = 1'b1;
			if (if_id_use.reads_sr2 && (sr2_of(if_id.ir) == ld_dr))
				load_use = 1'b1;
			// store data register in ir[11:9]
			if (if_id_use.reads_store_src && (dr_of(if_id.ir) == ld_dr))
				load_use = 1'b1;
		end
	end

	assign moves_pc = if_id_op inside {op_br, op_jmp, op_jsr, op_trap};

	// the all-zero word is the nop and opens no shadow
	// a branch held by a load-use stall waits until it really moves on
	assign shadow_start = if_id.valid && (if_id.ir != '0) && moves_pc &&
		(shadow_cnt == 3'd0) && !load_use;

	// counts down once started, no restart from inside a shadow
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			shadow_cnt <= 3'd0;
		else if (shadow_cnt != 3'd0)
			shadow_cnt <= shadow_cnt - 3'd1;
		else if (shadow_start)
			shadow_cnt <= resolve_delay;	// branch itself moves on this edge
	end

	// above 2 hold fetch and decode
	// at 2 kill the fall-through held in IF/ID
	// at 1 the cleared IF/ID drains into ID/EX while the target is fetched
	assign stall  = load_use || (shadow_cnt > 3'd2);
	assign squash = (shadow_cnt == 3'd2);

endmodule

// ==== hw/lc3b_front.sv ====
`timescale 1ns/100ps

// in-order issue front end: fetch, IF/ID, ID/EX and hazard control
module lc3b_front
	import lc3b_isa_pkg::*, lc3b_pipe_pkg::*;
#(
	parameter logic [2:0] resolve_delay = 3'd5	// cycles until a target is known
)
(
	input  logic   clk,
	input  logic   rst_n,
	input  instr_t fetch_ir,	// combinational read of fetch_addr
	input  logic   redirect,	// target resolved downstream
	input  addr_t  redirect_pc,
	output addr_t  fetch_addr,
	output stage_t issue	// instruction entering execute
);

	stage_t fetched;
	stage_t if_id;
	stage_t id_ex;
	logic   stall;
	logic   squash;

	fetch_unit fetch_i
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.stall       (stall),
		.squash      (squash),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.fetch_ir    (fetch_ir),
		.fetch_addr  (fetch_addr),
		.fetched     (fetched)
	);

	stage_regs stage_i
	(
		.clk     (clk),
		.rst_n   (rst_n),
		.stall   (stall),
		.squash  (squash),
		.fetched (fetched),
		.if_id   (if_id),
		.id_ex   (id_ex)
	);

	hazard_unit #(
		.resolve_delay (resolve_delay)
	) hazard_i
	(
		.clk    (clk),
		.rst_n  (rst_n),
		.if_id  (if_id),
		.id_ex  (id_ex),
		.stall  (stall),
		.squash (squash)
	);

	assign issue = id_ex;	// no back-pressure from execute

endmodule

// ==== verif/lc3b_front_tb.sv ====
`timescale 1ns/100ps

// testbench for the lc3b issue front end
// program memory answers fetch_addr combinationally, targets come from a side table
module lc3b_front_tb
	import lc3b_isa_pkg::*, lc3b_pipe_pkg::*;
;

	localparam logic [2:0] resolve_delay = 3'd5;	// same value in the DUT and the model
	localparam int         mem_words     = 512;

	logic   clk = 1'b0;
	logic   rst_n = 1'b0;
	logic   redirect = 1'b0;
	addr_t  redirect_pc = '0;
	instr_t fetch_ir;
	addr_t  fetch_addr;
	stage_t issue;

	instr_t     mem [mem_words];	// word indexed by pc[9:1]
	logic [8:0] targ [mem_words];	// resolved target word per pc-moving slot
	stage_t     exp_q [$];	// expected issue, one entry per cycle
	logic [15:0] lfsr = 16'd60;

	lc3b_front #(
		.resolve_delay (resolve_delay)
	) dut_i
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.fetch_ir    (fetch_ir),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.fetch_addr  (fetch_addr),
		.issue       (issue)
	);

	assign fetch_ir = mem[fetch_addr[9:1]];

	initial
	begin
		forever
			#2 clk = ~clk;	// 4 ns period
	end

	// galois form, taps 16,14,13,11
	function automatic logic [15:0] lfsr_next(logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	function automatic logic [15:0] random_bits(int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v    = {v[14:0], lfsr[0]};	// one step per bit
			lfsr = lfsr_next(lfsr);
		end
		return v;
	endfunction

	function automatic instr_t make_instr(opcode_e op, reg_idx_t a, reg_idx_t b, logic [5:0] low);
		return {op, a, b, low};
	endfunction

	// br, jmp, jsr and trap move the pc; the zero word is the nop
	function automatic logic moves_pc(instr_t ir);
		opcode_e op;
		op = opcode_e'(ir[15:12]);
		return (ir != '0) && (op inside {op_br, op_jmp, op_jsr, op_trap});
	endfunction

	function automatic logic is_load(instr_t ir);
		opcode_e op;
		op = opcode_e'(ir[15:12]);
		return op inside {op_ldb, op_ldr, op_ldi};
	endfunction

	// does ir read register r through sr1, sr2 or the store source
	function automatic logic reads_reg(instr_t ir, reg_idx_t r);
		opcode_e op;
		op = opcode_e'(ir[15:12]);
		case (op)
			op_add, op_and:
				return (ir[8:6] == r) || (!ir[5] && (ir[2:0] == r));
			op_not, op_shf, op_ldb, op_ldr, op_ldi, op_jmp:
				return ir[8:6] == r;
			op_stb, op_str, op_sti:
				return (ir[11:9] == r) || (ir[8:6] == r);	// data or base
			op_jsr:
				return !ir[11] && (ir[8:6] == r);	// register form only
			default:
				return 1'b0;
		endcase
	endfunction

	// walks the program in architectural order and lays out the per-cycle issue stream
	function automatic void build_expected(int n_instr);
		addr_t  pc;
		instr_t ir;
		instr_t prev;
		stage_t s;
		exp_q.delete();
		exp_q.push_back(stage_empty);	// first cycle, IF/ID still empty
		exp_q.push_back(stage_empty);	// word 0 sits in IF/ID
		pc   = '0;
		prev = '0;
		for (int k = 0; k < n_instr; k++)
		begin
			ir = mem[pc[9:1]];
			if (moves_pc(prev))
			begin
				for (int i = 0; i < resolve_delay; i++)
					exp_q.push_back(stage_empty);	// control shadow
			end
			else if (is_load(prev) && reads_reg(ir, prev[11:9]))
				exp_q.push_back(stage_empty);	// load-use
			s.valid = 1'b1;
			s.pc    = pc;
			s.ir    = ir;
			exp_q.push_back(s);
			prev = ir;
			pc   = moves_pc(ir) ? {6'b0, targ[pc[9:1]], 1'b0} : pc + 16'd2;
		end
	endfunction

	task automatic compare_stage(string name, stage_t got, stage_t want);
		if (got !== want)
		begin
			$display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, want);
			$display("TESTS FAILED");
			$fatal(1, "stopping at first error");
		end
	endtask

	task automatic compare_addr(string name, addr_t got, addr_t want);
		if (got !== want)
		begin
			$display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, want);
			$display("TESTS FAILED");
			$fatal(1, "stopping at first error");
		end
	endtask

	// target resolves downstream; pulse one edge after the mover leaves ID/EX
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			redirect    <= 1'b0;
			redirect_pc <= '0;
		end
		else if (issue.valid && moves_pc(issue.ir))
		begin
			redirect    <= 1'b1;
			redirect_pc <= {6'b0, targ[issue.pc[9:1]], 1'b0};
		end
		else
			redirect <= 1'b0;
	end

	task automatic put(int word, instr_t ir, int target_word);
		mem[word]  = ir;
		targ[word] = 9'(target_word);
	endtask

	// memory is refilled with a pattern of the address and reset goes low
	task automatic start_reset();
		for (int i = 0; i < mem_words; i++)
		begin
			mem[i]  = {4'h1, 9'(i), 3'b000};	// an add, differs per word
			targ[i] = '0;
		end
		@(posedge clk);
		rst_n <= 1'b0;
	endtask

	task automatic run_test(string name, int n_instr);
		int idx;
		build_expected(n_instr);
		$display("running %s, %0d cycles expected", name, exp_q.size());
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		compare_addr("fetch_addr", fetch_addr, '0);	// pc starts at 0
		idx = 0;
		while (idx < exp_q.size())
		begin
			if (idx > 0)
				@(negedge clk);	// mid-cycle, outputs are settled
			compare_stage("issue", issue, exp_q[idx]);
			idx++;
		end
	endtask

	initial
	begin
		reg_idx_t d;
		reg_idx_t b;
		reg_idx_t d2;
		reg_idx_t d3;

		// straight-line alu code
		start_reset();
		for (int i = 0; i < 12; i++)
		begin
			case (i % 3)
				0: put(i, make_instr(op_add, 3'(random_bits(3)), 3'(random_bits(3)),
					6'(random_bits(6))), 0);
				1: put(i, make_instr(op_and, 3'(random_bits(3)), 3'(random_bits(3)),
					6'(random_bits(6))), 0);
				default: put(i, make_instr(op_not, 3'(random_bits(3)), 3'(random_bits(3)),
					6'h3f), 0);
			endcase
		end
		run_test("straight line", 12);

		// load-use through sr1, sr2, store source, and followers that do not read
		start_reset();
		d  = 3'(random_bits(3));
		b  = 3'(random_bits(3));
		d2 = 3'(random_bits(3));
		d3 = 3'(random_bits(3));
		put(0, make_instr(op_ldr, d, b, 6'h02), 0);
		put(1, make_instr(op_add, b, d, 6'h25), 0);	// sr1 reader
		put(2, make_instr(op_ldb, d2, b, 6'h00), 0);
		put(3, make_instr(op_and, b, d2 + 3'd1, {3'b000, d2}), 0);	// sr2 reader
		put(4, make_instr(op_ldi, d3, b, 6'h01), 0);
		put(5, make_instr(op_str, d3, d3 + 3'd1, 6'h00), 0);	// store data reader
		put(6, make_instr(op_ldr, d, b, 6'h00), 0);
		put(7, make_instr(op_add, d, d + 3'd1, {3'b100, d}), 0);	// imm form, no read
		put(8, make_instr(op_ldr, d2, b, 6'h00), 0);
		put(9, make_instr(op_lea, d2, 3'd0, 6'h00), 0);	// writes only
		put(10, make_instr(op_ldr, d, b, 6'h00), 0);
		put(11, make_instr(op_jmp, 3'd0, d, 6'h00), 40);	// branch base from a load
		run_test("load use", 15);

		// each kind of pc mover
		start_reset();
		put(1, make_instr(op_br, 3'b111, 3'(random_bits(3)), 6'(random_bits(6))), 16);
		put(17, make_instr(op_jmp, 3'd0, 3'(random_bits(3)), 6'h00), 32);
		put(32, make_instr(op_jsr, 3'b100, 3'(random_bits(3)), 6'(random_bits(6))), 48);
		put(48, make_instr(op_trap, 3'd0, 3'd0, 6'h25), 64);
		run_test("branches", 9);

		// zero word is a plain nop
		start_reset();
		put(1, '0, 0);
		put(3, '0, 0);
		run_test("nop", 6);

		// load-use right at a target, then movers landing on movers
		start_reset();
		d = 3'(random_bits(3));
		put(0, make_instr(op_br, 3'b001, 3'd0, 6'h05), 20);
		put(20, make_instr(op_ldr, d, 3'd2, 6'h00), 0);
		put(21, make_instr(op_add, 3'd1, d, 6'h00), 0);
		put(22, make_instr(op_br, 3'b010, 3'd0, 6'h11), 40);
		put(40, make_instr(op_jmp, 3'd0, 3'd7, 6'h00), 60);	// ret
		put(60, make_instr(op_br, 3'b100, 3'd3, 6'h01), 80);
		put(80, make_instr(op_jsr, 3'b100, 3'd0, 6'h10), 100);
		put(81, make_instr(op_br, 3'b111, 3'd0, 6'h01), 120);	// fall-through, squashed
		put(100, make_instr(op_trap, 3'd0, 3'd0, 6'h20), 130);
		run_test("after target", 12);

		// long random mix, rti left out
		start_reset();
		for (int i = 0; i < mem_words; i++)
		begin
			logic [3:0] op;
			op = 4'(random_bits(4));
			if (op == 4'h8)
				op = 4'h1;
			put(i, {op, 12'(random_bits(12))}, int'(random_bits(9)));
		end
		run_test("random", 400);

		$display("TESTS PASSED");
		$finish;
	end

	// whole-run guard
	initial
	begin
		for (int i = 0; i < 40000; i++)
			@(posedge clk);
		$display("timed out: simulation ran past its cycle limit");
		$display("TESTS FAILED");
		$fatal(1, "stopping on timeout");
	end

endmodule

// ==== list.f ====
hw/lc3b_isa_pkg.sv
hw/lc3b_pipe_pkg.sv
hw/fetch_unit.sv
hw/stage_regs.sv
hw/operand_use_decoder.sv
hw/hazard_unit.sv
hw/lc3b_front.sv
verif/lc3b_front_tb.sv

// ==== run.sh ====
#!/bin/bash
# build and run the lc3b front end testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -f list.f --top-module lc3b_front_tb -o sim_lc3b \
	> build.log 2>&1 \
	&& ./obj_dir/sim_lc3b > sim.log 2>&1 \
	|| echo "build or simulation returned an error, see build.log and sim.log"

grep -q "TESTS PASSED" sim.log 2>/dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
